//--- regblk_pkg.sv
package regblk_pkg;

  // Bus and field widths
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int OFFSET_W = 8;
  localparam int STATUS_W = 8;
  localparam int TRIG_W   = 4;
  localparam int NUM_REGS = 5;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [STRB_W-1:0]   strb_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [STATUS_W-1:0] status_t;
  typedef logic [TRIG_W-1:0]   trig_t;
  typedef logic [NUM_REGS-1:0] reg_sel_t;

  // Bit positions inside reg_sel_t
  localparam int SEL_CTRL     = 0;
  localparam int SEL_IRQ_EN   = 1;
  localparam int SEL_STATUS   = 2;
  localparam int SEL_HW_VALUE = 3;
  localparam int SEL_TRIGGER  = 4;

  // Address map
  localparam addr_t   BASE_ADDRESS = 16'h1000;
  localparam addr_t   WINDOW_SIZE  = 16'h0100;
  localparam offset_t OFS_CTRL     = 8'h00;
  localparam offset_t OFS_IRQ_EN   = 8'h04;
  localparam offset_t OFS_STATUS   = 8'h08;
  localparam offset_t OFS_HW_VALUE = 8'h0c;
  localparam offset_t OFS_TRIGGER  = 8'h10;

  localparam data_t DEFAULT_READ_DATA = 32'hdead_beef;

  typedef struct packed {
    logic  psel;
    logic  penable;
    addr_t paddr;
    logic  pwrite;
    strb_t pstrb;
    data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    data_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  // Internal register access, one per APB transfer
  typedef struct packed {
    logic    valid;
    logic    write;
    offset_t offset;
    data_t   wdata;
    strb_t   strb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } reg_rsp_t;

endpackage

//--- apb_slave_port.sv
`timescale 1ns/1ps

module apb_slave_port (
  input  logic                 clk,
  input  logic                 i_reset,
  input  regblk_pkg::apb_req_t i_apb,
  output regblk_pkg::apb_rsp_t o_apb,
  output regblk_pkg::reg_req_t o_req,
  input  regblk_pkg::reg_rsp_t i_rsp
);

  typedef enum logic {
    IDLE,
    RESP
  } state_t;

  state_t state_q;
  state_t state_d;

  logic              access;
  logic              issue;
  regblk_pkg::data_t rdata_q;
  logic              error_q;

  // First access cycle of a transfer
  assign access = i_apb.psel && i_apb.penable;
  assign issue  = (state_q == IDLE) && access;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (access) begin
          state_d = RESP;
        end
      end
      RESP: begin
        // pready is high for this cycle only
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response captured at the edge that ends the first access cycle
  always_ff @(posedge clk) begin
    if (issue) begin
      rdata_q <= i_rsp.rdata;
      error_q <= i_rsp.error;
    end
  end

  always_comb begin
    o_req.valid  = issue;
    o_req.write  = i_apb.pwrite;
    o_req.offset = i_apb.paddr[regblk_pkg::OFFSET_W-1:0];
    o_req.wdata  = i_apb.pwdata;
    o_req.strb   = i_apb.pstrb;
  end

  always_comb begin
    o_apb.pready  = (state_q == RESP);
    o_apb.prdata  = rdata_q;
    // Error only qualifies the completing cycle
    o_apb.pslverr = error_q && (state_q == RESP);
  end

endmodule

//--- reg_decoder.sv
`timescale 1ns/1ps

module reg_decoder (
  input  regblk_pkg::reg_req_t i_req,
  input  regblk_pkg::addr_t    i_apb_addr,
  output regblk_pkg::reg_rsp_t o_rsp,
  output regblk_pkg::reg_sel_t o_wr_sel,
  output regblk_pkg::data_t    o_wdata,
  output regblk_pkg::strb_t    o_strb,
  input  regblk_pkg::data_t    i_ctrl,
  input  regblk_pkg::status_t  i_irq_en,
  input  regblk_pkg::status_t  i_status,
  input  regblk_pkg::data_t    i_hw_value
);

  regblk_pkg::reg_sel_t hit;
  regblk_pkg::reg_sel_t wr_hit;
  regblk_pkg::data_t    rdata;
  logic                 in_window;
  logic                 error;

  // Word match, byte address bits 1:0 ignored
  function automatic logic ofs_match(regblk_pkg::offset_t a, regblk_pkg::offset_t b);
    return a[regblk_pkg::OFFSET_W-1:2] == b[regblk_pkg::OFFSET_W-1:2];
  endfunction

  assign in_window = (i_apb_addr >= regblk_pkg::BASE_ADDRESS) &&
                     (i_apb_addr <  regblk_pkg::BASE_ADDRESS + regblk_pkg::WINDOW_SIZE);

  always_comb begin
    hit                          = '0;
    hit[regblk_pkg::SEL_CTRL]     = ofs_match(i_req.offset, regblk_pkg::OFS_CTRL);
    hit[regblk_pkg::SEL_IRQ_EN]   = ofs_match(i_req.offset, regblk_pkg::OFS_IRQ_EN);
    hit[regblk_pkg::SEL_STATUS]   = ofs_match(i_req.offset, regblk_pkg::OFS_STATUS);
    hit[regblk_pkg::SEL_HW_VALUE] = ofs_match(i_req.offset, regblk_pkg::OFS_HW_VALUE);
    hit[regblk_pkg::SEL_TRIGGER]  = ofs_match(i_req.offset, regblk_pkg::OFS_TRIGGER);
  end

  assign error = !in_window || (hit == '0);

  always_comb begin
    wr_hit = hit;
    // HW_VALUE is read-only, a write completes but changes nothing
    wr_hit[regblk_pkg::SEL_HW_VALUE] = 1'b0;
    if (i_req.valid && i_req.write && !error) begin
      o_wr_sel = wr_hit;
    end else begin
      o_wr_sel = '0;
    end
  end

  assign o_wdata = i_req.wdata;
  assign o_strb  = i_req.strb;

  // Read mux, narrow registers zero-extended
  always_comb begin
    rdata = '0;
    if (error) begin
      rdata = regblk_pkg::DEFAULT_READ_DATA;
    end else begin
      if (hit[regblk_pkg::SEL_CTRL]) begin
        rdata = i_ctrl;
      end
      if (hit[regblk_pkg::SEL_IRQ_EN]) begin
        rdata = regblk_pkg::data_t'(i_irq_en);
      end
      if (hit[regblk_pkg::SEL_STATUS]) begin
        rdata = regblk_pkg::data_t'(i_status);
      end
      if (hit[regblk_pkg::SEL_HW_VALUE]) begin
        rdata = i_hw_value;
      end
      // TRIGGER is write-only and reads as zero
    end
  end

  always_comb begin
    o_rsp.rdata = rdata;
    o_rsp.error = error;
  end

endmodule

//--- ctrl_register.sv
`timescale 1ns/1ps

module ctrl_register #(
  parameter int WIDTH = 32
) (
  input  logic              clk,
  input  logic              i_reset,
  input  logic              i_wr,
  input  regblk_pkg::data_t i_wdata,
  input  regblk_pkg::strb_t i_strb,
  output logic [WIDTH-1:0]  o_value
);

  regblk_pkg::data_t lane_mask;
  logic [WIDTH-1:0]  bit_mask;
  logic [WIDTH-1:0]  value_q;
  logic [WIDTH-1:0]  value_d;

  // Expand byte strobes to a bit mask
  always_comb begin
    for (int lane = 0; lane < regblk_pkg::STRB_W; lane++) begin
      lane_mask[lane*8 +: 8] = {8{i_strb[lane]}};
    end
  end

  assign bit_mask = lane_mask[WIDTH-1:0];

  // Merge strobed lanes into the held value
  always_comb begin
    value_d = value_q;
    if (i_wr) begin
      value_d = (value_q & ~bit_mask) | (i_wdata[WIDTH-1:0] & bit_mask);
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      value_q <= '0;
    end else begin
      value_q <= value_d;
    end
  end

  assign o_value = value_q;

endmodule

//--- status_register.sv
`timescale 1ns/1ps

module status_register (
  input  logic                clk,
  input  logic                i_reset,
  input  logic                i_wr,
  input  regblk_pkg::data_t   i_wdata,
  input  regblk_pkg::strb_t   i_strb,
  input  regblk_pkg::status_t i_events,
  input  regblk_pkg::status_t i_irq_en,
  output regblk_pkg::status_t o_status,
  output logic                o_irq
);

  regblk_pkg::status_t status_q;
  regblk_pkg::status_t status_d;
  regblk_pkg::status_t clr;
  regblk_pkg::status_t pending;

  // Write 1 to clear, only through byte lane 0
  always_comb begin
    clr = '0;
    if (i_wr && i_strb[0]) begin
      clr = i_wdata[regblk_pkg::STATUS_W-1:0];
    end
  end

  // Hardware set applied after the clear so it wins
  always_comb begin
    status_d = status_q & ~clr;
    status_d = status_d | i_events;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign o_status = status_q;

  // Interrupt from enabled sticky bits
  assign pending = status_q & i_irq_en;
  assign o_irq   = |pending;

endmodule

//--- trigger_register.sv
`timescale 1ns/1ps

module trigger_register (
  input  logic              clk,
  input  logic              i_reset,
  input  logic              i_wr,
  input  regblk_pkg::data_t i_wdata,
  input  regblk_pkg::strb_t i_strb,
  output regblk_pkg::trig_t o_trigger
);

  regblk_pkg::trig_t pulse_q;

  // Held for one cycle, cleared whenever no write arrives
  always_ff @(posedge clk) begin
    if (i_reset) begin
      pulse_q <= '0;
    end else if (i_wr && i_strb[0]) begin
      pulse_q <= i_wdata[regblk_pkg::TRIG_W-1:0];
    end else begin
      pulse_q <= '0;
    end
  end

  assign o_trigger = pulse_q;

endmodule

//--- apb_regblk_top.sv
`timescale 1ns/1ps

module apb_regblk_top (
  input  logic                 clk,
  input  logic                 i_reset,
  input  regblk_pkg::apb_req_t i_apb,
  output regblk_pkg::apb_rsp_t o_apb,
  input  regblk_pkg::status_t  i_events,
  input  regblk_pkg::data_t    i_hw_value,
  output regblk_pkg::data_t    o_ctrl,
  output regblk_pkg::trig_t    o_trigger,
  output logic                 o_irq
);

  regblk_pkg::reg_req_t req;
  regblk_pkg::reg_rsp_t rsp;
  regblk_pkg::reg_sel_t wr_sel;
  regblk_pkg::data_t    wdata;
  regblk_pkg::strb_t    strb;
  regblk_pkg::status_t  irq_en;
  regblk_pkg::status_t  status;

  apb_slave_port u_port (
    .clk     (clk),
    .i_reset (i_reset),
    .i_apb   (i_apb),
    .o_apb   (o_apb),
    .o_req   (req),
    .i_rsp   (rsp)
  );

  reg_decoder u_decoder (
    .i_req      (req),
    .i_apb_addr (i_apb.paddr),
    .o_rsp      (rsp),
    .o_wr_sel   (wr_sel),
    .o_wdata    (wdata),
    .o_strb     (strb),
    .i_ctrl     (o_ctrl),
    .i_irq_en   (irq_en),
    .i_status   (status),
    .i_hw_value (i_hw_value)
  );

  ctrl_register #(
    .WIDTH (regblk_pkg::DATA_W)
  ) u_ctrl (
    .clk     (clk),
    .i_reset (i_reset),
    .i_wr    (wr_sel[regblk_pkg::SEL_CTRL]),
    .i_wdata (wdata),
    .i_strb  (strb),
    .o_value (o_ctrl)
  );

  ctrl_register #(
    .WIDTH (regblk_pkg::STATUS_W)
  ) u_irq_en (
    .clk     (clk),
    .i_reset (i_reset),
    .i_wr    (wr_sel[regblk_pkg::SEL_IRQ_EN]),
    .i_wdata (wdata),
    .i_strb  (strb),
    .o_value (irq_en)
  );

  status_register u_status (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_wr     (wr_sel[regblk_pkg::SEL_STATUS]),
    .i_wdata  (wdata),
    .i_strb   (strb),
    .i_events (i_events),
    .i_irq_en (irq_en),
    .o_status (status),
    .o_irq    (o_irq)
  );

  trigger_register u_trigger (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_wr      (wr_sel[regblk_pkg::SEL_TRIGGER]),
    .i_wdata   (wdata),
    .i_strb    (strb),
    .o_trigger (o_trigger)
  );

endmodule

//--- tb_apb_regblk.sv
`timescale 1ns/1ps

module tb_apb_regblk;

  localparam int READY_TIMEOUT = 16;

  localparam logic [1:0] OP_READ  = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_EVENT = 2'd2;

  localparam regblk_pkg::addr_t BASE = regblk_pkg::BASE_ADDRESS;
  localparam regblk_pkg::addr_t A_CTRL     = BASE + {8'h00, regblk_pkg::OFS_CTRL};
  localparam regblk_pkg::addr_t A_IRQ_EN   = BASE + {8'h00, regblk_pkg::OFS_IRQ_EN};
  localparam regblk_pkg::addr_t A_STATUS   = BASE + {8'h00, regblk_pkg::OFS_STATUS};
  localparam regblk_pkg::addr_t A_HW_VALUE = BASE + {8'h00, regblk_pkg::OFS_HW_VALUE};
  localparam regblk_pkg::addr_t A_TRIGGER  = BASE + {8'h00, regblk_pkg::OFS_TRIGGER};

  typedef struct packed {
    logic [1:0]          op;
    regblk_pkg::addr_t   addr;
    regblk_pkg::data_t   data;
    regblk_pkg::strb_t   strb;
    regblk_pkg::data_t   exp_rdata;
    logic                check_rdata;
    logic                exp_err;
    logic                exp_irq;
    regblk_pkg::trig_t   exp_trig;
    regblk_pkg::data_t   exp_ctrl;
  } step_t;

  logic                 clk;
  logic                 i_reset;
  regblk_pkg::apb_req_t apb_req;
  regblk_pkg::apb_rsp_t apb_rsp;
  regblk_pkg::status_t  hw_events;
  regblk_pkg::data_t    hw_value;
  regblk_pkg::data_t    ctrl;
  regblk_pkg::trig_t    trigger;
  logic                 irq;

  step_t               steps[$];
  logic [31:0]         lfsr;
  int                  errors;
  int                  timeouts;
  int                  cur_step;
  // Expected register contents while the table is built
  regblk_pkg::data_t   ctrl_model;
  regblk_pkg::status_t irq_en_model;
  regblk_pkg::status_t status_model;

  apb_regblk_top dut (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_apb      (apb_req),
    .o_apb      (apb_rsp),
    .i_events   (hw_events),
    .i_hw_value (hw_value),
    .o_ctrl     (ctrl),
    .o_trigger  (trigger),
    .o_irq      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic lfsr_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic regblk_pkg::data_t random_word();
    regblk_pkg::data_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic regblk_pkg::data_t merge_bytes(regblk_pkg::data_t old_value,
                                                    regblk_pkg::data_t new_value,
                                                    regblk_pkg::strb_t strb);
    regblk_pkg::data_t result;
    result = old_value;
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        result[lane*8 +: 8] = new_value[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  // Outside the window or past the last register word
  function automatic logic map_error(regblk_pkg::addr_t addr);
    return (addr < BASE) || (addr >= BASE + regblk_pkg::WINDOW_SIZE) || (addr[7:2] > 6'd4);
  endfunction

  task automatic check(input string what, input regblk_pkg::data_t got,
                       input regblk_pkg::data_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: step %0d, %s: got %h, expected %h",
               $time, cur_step, what, got, exp);
    end
  endtask

  task automatic add_step(input logic [1:0] op, input regblk_pkg::addr_t addr,
                          input regblk_pkg::data_t data, input regblk_pkg::strb_t strb);
    step_t             s;
    logic              err;
    regblk_pkg::data_t merged;
    err           = (op != OP_EVENT) && map_error(addr);
    s.op          = op;
    s.addr        = addr;
    s.data        = data;
    s.strb        = strb;
    s.exp_err     = err;
    s.exp_trig    = '0;
    s.exp_rdata   = regblk_pkg::DEFAULT_READ_DATA;
    s.check_rdata = (op == OP_READ) || err;
    if (op == OP_EVENT) begin
      status_model = status_model | data[7:0];
    end else if (!err && op == OP_READ) begin
      case (addr[7:2])
        6'd0: s.exp_rdata = ctrl_model;
        6'd1: s.exp_rdata = {24'h0, irq_en_model};
        6'd2: s.exp_rdata = {24'h0, status_model};
        6'd3: s.exp_rdata = hw_value;
        default: s.exp_rdata = '0;
      endcase
    end else if (!err) begin
      case (addr[7:2])
        6'd0: ctrl_model = merge_bytes(ctrl_model, data, strb);
        6'd1: begin
          merged       = merge_bytes({24'h0, irq_en_model}, data, strb);
          irq_en_model = merged[7:0];
        end
        6'd2: status_model = strb[0] ? (status_model & ~data[7:0]) : status_model;
        6'd4: s.exp_trig = strb[0] ? data[3:0] : 4'h0;
        default: ;
      endcase
    end
    s.exp_irq  = |(status_model & irq_en_model);
    s.exp_ctrl = ctrl_model;
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Reset values
    add_step(OP_READ, A_CTRL, '0, 4'h0);
    add_step(OP_READ, A_IRQ_EN, '0, 4'h0);
    add_step(OP_READ, A_STATUS, '0, 4'h0);
    add_step(OP_READ, A_HW_VALUE, '0, 4'h0);
    add_step(OP_READ, A_TRIGGER, '0, 4'h0);
    // CTRL with partial strobes
    add_step(OP_WRITE, A_CTRL, random_word(), 4'hf);
    add_step(OP_READ, A_CTRL, '0, 4'h0);
    add_step(OP_WRITE, A_CTRL, random_word(), 4'b0101);
    add_step(OP_READ, A_CTRL, '0, 4'h0);
    add_step(OP_WRITE, A_CTRL, random_word(), 4'b1000);
    add_step(OP_WRITE, A_CTRL, random_word(), 4'b0000);
    add_step(OP_READ, A_CTRL, '0, 4'h0);
    // Sticky status and interrupt
    add_step(OP_WRITE, A_IRQ_EN, 32'hffff_ff0f, 4'hf);
    add_step(OP_EVENT, '0, 32'h30, 4'h0);
    add_step(OP_EVENT, '0, 32'h02, 4'h0);
    add_step(OP_READ, A_STATUS, '0, 4'h0);
    add_step(OP_WRITE, A_STATUS, 32'h02, 4'h1);
    add_step(OP_READ, A_STATUS, '0, 4'h0);
    add_step(OP_WRITE, A_IRQ_EN, 32'h0000_f0f0, 4'b0010);
    add_step(OP_WRITE, A_IRQ_EN, 32'h0000_00f0, 4'h1);
    add_step(OP_READ, A_IRQ_EN, '0, 4'h0);
    add_step(OP_WRITE, A_STATUS, 32'hffff_ffff, 4'b1110);
    add_step(OP_READ, A_STATUS, '0, 4'h0);
    add_step(OP_WRITE, A_STATUS, 32'h0000_00ff, 4'h1);
    add_step(OP_READ, A_STATUS, '0, 4'h0);
    // Trigger pulses
    add_step(OP_WRITE, A_TRIGGER, 32'ha, 4'h1);
    add_step(OP_WRITE, A_TRIGGER, 32'h5, 4'b0010);
    add_step(OP_READ, A_TRIGGER, '0, 4'h0);
    // Errors leave every register untouched
    add_step(OP_EVENT, '0, 32'h81, 4'h0);
    add_step(OP_READ, 16'h0ffc, '0, 4'h0);
    add_step(OP_WRITE, 16'h1100, random_word(), 4'hf);
    add_step(OP_READ, 16'h1014, '0, 4'h0);
    add_step(OP_WRITE, 16'h1040, random_word(), 4'hf);
    add_step(OP_READ, 16'h10fc, '0, 4'h0);
    add_step(OP_WRITE, 16'h2008, 32'h0000_00ff, 4'hf);
    add_step(OP_READ, A_CTRL, '0, 4'h0);
    add_step(OP_READ, A_STATUS, '0, 4'h0);
    add_step(OP_READ, A_IRQ_EN + 16'h2, '0, 4'h0);
    // HW_VALUE ignores writes
    add_step(OP_WRITE, A_HW_VALUE, random_word(), 4'hf);
    add_step(OP_READ, A_HW_VALUE, '0, 4'h0);
  endtask

  task automatic run_transfer(input step_t s);
    int   waits;
    logic ready_seen;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.paddr   = s.addr;
    apb_req.pwrite  = (s.op == OP_WRITE);
    apb_req.pstrb   = s.strb;
    apb_req.pwdata  = s.data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    check("pready in first access cycle", 32'(apb_rsp.pready), 0);
    check("o_trigger before write edge", 32'(trigger), 0);
    waits      = 0;
    ready_seen = 1'b0;
    while (!ready_seen && waits < READY_TIMEOUT) begin
      @(negedge clk);
      waits++;
      ready_seen = apb_rsp.pready;
    end
    if (!ready_seen) begin
      timeouts++;
      $display("Timeout: pready never rose for step %0d within %0d cycles",
               cur_step, READY_TIMEOUT);
    end else begin
      check("wait states", waits, 1);
      check("pslverr", 32'(apb_rsp.pslverr), 32'(s.exp_err));
      if (s.check_rdata) begin
        check("prdata", apb_rsp.prdata, s.exp_rdata);
      end
      check("o_trigger pulse", 32'(trigger), 32'(s.exp_trig));
    end
    @(negedge clk);
    apb_req = '0;
    check("o_trigger after pulse", 32'(trigger), 0);
    check("o_irq", 32'(irq), 32'(s.exp_irq));
    check("o_ctrl", ctrl, s.exp_ctrl);
  endtask

  task automatic pulse_events(input step_t s);
    @(negedge clk);
    hw_events = s.data[7:0];
    @(negedge clk);
    hw_events = '0;
    check("o_irq after event", 32'(irq), 32'(s.exp_irq));
  endtask

  initial begin
    errors       = 0;
    timeouts     = 0;
    cur_step     = 0;
    lfsr         = 32'h0000_50bf;
    i_reset      = 1'b1;
    apb_req      = '0;
    hw_events    = '0;
    hw_value     = random_word();
    ctrl_model   = '0;
    irq_en_model = '0;
    status_model = '0;
    build_table();
    repeat (3) @(negedge clk);
    i_reset = 1'b0;
    check("pready after reset", 32'(apb_rsp.pready), 0);
    check("pslverr after reset", 32'(apb_rsp.pslverr), 0);
    check("o_trigger after reset", 32'(trigger), 0);
    check("o_irq after reset", 32'(irq), 0);
    for (int i = 0; i < steps.size(); i++) begin
      cur_step = i;
      if (steps[i].op == OP_EVENT) begin
        pulse_events(steps[i]);
      end else begin
        run_transfer(steps[i]);
      end
    end
    repeat (2) @(negedge clk);
    $display("Steps %0d, mismatches %0d, timeouts %0d", steps.size(), errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
regblk_pkg.sv
apb_slave_port.sv
reg_decoder.sv
ctrl_register.sv
status_register.sv
trigger_register.sv
apb_regblk_top.sv
tb_apb_regblk.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_apb_regblk
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
